// File: dv/pong_sva.sv
`timescale 1ns/1ps
`include "pong_params.svh"

module pong_assertions (
        input logic               CLOCK_50,
        input logic               KEY,
        input logic               two_pucks,
        input logic               plot,
        input pong_pkg::coord_x_t draw_x,
        input pong_pkg::coord_y_t draw_y,
        input pong_pkg::colour_t  colour
);

        // raised by any failing assertion, the testbench watches it
        logic               failed = 1'b0;
        logic               seen, clearing, yel_q, run_valid, in_frame;
        logic               two_sel, tp_q1, tp_q2;
        logic               yel, pur, clr_start, pidx;
        logic [1:0]         pvalid, pcount;
        pong_pkg::coord_x_t clr_x, run_x;
        pong_pkg::coord_y_t clr_y;
        pong_pkg::coord_x_t px [2];
        pong_pkg::coord_y_t py [2];

        assign yel  = plot && colour == pong_pkg::YELLOW;
        assign pur  = plot && colour == pong_pkg::PURPLE;
        assign pidx = pcount[0];

        // a clear is the only black pixel ever plotted at the origin
        assign clr_start = plot && colour == pong_pkg::BLACK && draw_x == 8'd0 && draw_y == 7'd0;

        function automatic void report_failure(input string what);
                failed = 1'b1;
                $error("Error %0t: %s", $time, what);
        endfunction

        // ==================================================================
        // tracking of clears, paddle runs and puck pixels
        // ==================================================================

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        seen      <= 1'b0;
                        clearing  <= 1'b0;
                        yel_q     <= 1'b0;
                        run_valid <= 1'b0;
                        in_frame  <= 1'b0;
                        two_sel   <= 1'b0;
                        tp_q1     <= 1'b0;
                        tp_q2     <= 1'b0;
                        pvalid    <= 2'b00;
                        pcount    <= 2'd0;
                        clr_x     <= '0;
                        clr_y     <= '0;
                        run_x     <= '0;
                end else begin
                        // two_pucks is taken by the sequencer two edges before the clear
                        tp_q1 <= two_pucks;
                        tp_q2 <= tp_q1;
                        yel_q <= yel;
                        if (plot)
                                seen <= 1'b1;
                        if (clr_start) begin
                                clearing  <= 1'b1;
                                clr_x     <= 8'd1;
                                clr_y     <= 7'd0;
                                two_sel   <= tp_q2;
                                in_frame  <= 1'b0;
                                run_valid <= 1'b0;
                                pvalid    <= 2'b00;
                        end else if (plot && clearing) begin
                                if (clr_x == 8'(`SCREEN_W - 1)) begin
                                        clr_x    <= 8'd0;
                                        clr_y    <= clr_y + 7'd1;
                                        clearing <= (clr_y != 7'(`SCREEN_H - 1));
                                end else begin
                                        clr_x <= clr_x + 8'd1;
                                end
                        end
                        // each frame opens with the yellow paddle, pucks follow in order
                        if (yel && !yel_q) begin
                                run_x     <= draw_x;
                                run_valid <= 1'b1;
                                in_frame  <= 1'b1;
                                pcount    <= 2'd0;
                        end
                        if (pur) begin
                                px[pidx]     <= draw_x;
                                py[pidx]     <= draw_y;
                                pvalid[pidx] <= 1'b1;
                                pcount       <= pcount + 2'd1;
                        end
                end
        end

        // ==================================================================
        // drawing rules
        // ==================================================================

        a_on_screen: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                plot |-> draw_x < 8'(`SCREEN_W) && draw_y < 7'(`SCREEN_H))
                else report_failure("pixel plotted off the screen");

        // nothing is drawn after reset before the first clear
        a_first_plot: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                plot && !seen |-> clr_start)
                else report_failure("first pixel after reset is not the clear origin");

        a_clear_order: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                plot && clearing |->
                colour == pong_pkg::BLACK && draw_x == clr_x && draw_y == clr_y)
                else report_failure("clear pixel out of row-major order or not black");

        a_white: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                plot && colour == pong_pkg::WHITE |-> draw_y == 7'(`TOP_LINE) ||
                draw_x == 8'(`LEFT_LINE) || draw_x == 8'(`RIGHT_LINE))
                else report_failure("white pixel off the border");

        // the paddle moves by a whole step or not at all between frames
        a_run_start: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                yel && !yel_q |-> draw_x <= 8'(`RIGHT_LINE - `PADDLE_W - 1) &&
                (!run_valid || draw_x == run_x || draw_x == run_x + 8'd2 ||
                 draw_x + 8'd2 == run_x))
                else report_failure("paddle start column jumped or left the border");

        a_run_body: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                yel |-> draw_y == 7'(`PADDLE_ROW) && (!yel_q || draw_x == $past(draw_x) + 8'd1))
                else report_failure("yellow pixel off the paddle row or not consecutive");

        a_run_end: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                yel_q && !yel |-> $past(draw_x) == run_x + 8'(`PADDLE_W))
                else report_failure("paddle run has the wrong length");

        // a puck moves one pixel in both axes per frame
        a_puck_step: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                pur && pvalid[pidx] |->
                (draw_x == px[pidx] + 8'd1 || draw_x + 8'd1 == px[pidx]) &&
                (draw_y == py[pidx] + 7'd1 || draw_y + 7'd1 == py[pidx]))
                else report_failure("puck did not move one pixel diagonally");

        // a puck beside the paddle is never drawn, the game restarts instead
        a_no_miss_drawn: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                pur && draw_y == 7'(`PADDLE_ROW - 1) |->
                draw_x >= run_x && draw_x <= run_x + 8'(`PADDLE_W))
                else report_failure("puck drawn on the paddle row outside the paddle");

        a_puck_count: assert property (@(posedge CLOCK_50) disable iff (!KEY)
                yel && !yel_q && in_frame |-> pcount == (two_sel ? 2'd2 : 2'd1))
                else report_failure("wrong number of puck pixels in a frame");

endmodule

// the checker watches the drawing ports of every pong_top
bind pong_top pong_assertions checks (.*);

// File: dv/pong_tb.sv
`timescale 1ns/1ps

module pong_tb;

        logic               CLOCK_50 = 1'b0;
        logic               KEY;
        logic               right_btn;
        logic               left_btn;
        logic               two_pucks;
        logic               plot;
        pong_pkg::coord_x_t draw_x;
        pong_pkg::coord_y_t draw_y;
        pong_pkg::colour_t  colour;

        // stimulus mode, 0 keeps the buttons low while reset is held
        int          mode = 0;
        int          clears = 0;
        int          purples = 0;
        int          game_purples = 0;
        logic [31:0] rng = 32'h2d4c;

        pong_top #(.frame_delay(20)) dut0 (.*);

        always #4 CLOCK_50 = ~CLOCK_50;

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] v;
                v = s ^ (s << 13);
                v = v ^ (v >> 17);
                return v ^ (v << 5);
        endfunction

        // ==================================================================
        // stimulus, applied 1 ns after each rising edge
        // ==================================================================

        always @(posedge CLOCK_50) begin
                #1;
                rng = xorshift(rng);
                case (mode)
                        // 29 right steps park the paddle at column 134, where puck one lands
                        1: {right_btn, left_btn, two_pucks} = {game_purples < 29, 2'b00};
                        2: {right_btn, left_btn, two_pucks} = rng[2:0];
                        3: {right_btn, left_btn, two_pucks} = 3'b101;
                        4: {right_btn, left_btn, two_pucks} = 3'b010;
                        default: {right_btn, left_btn, two_pucks} = 3'b000;
                endcase
        end

        // outputs are sampled mid-cycle, a clear opens with black at the origin
        always @(negedge CLOCK_50) begin
                if (plot && colour == pong_pkg::BLACK && draw_x == 8'd0 && draw_y == 7'd0) begin
                        clears       <= clears + 1;
                        game_purples <= 0;
                end
                if (plot && colour == pong_pkg::PURPLE) begin
                        purples      <= purples + 1;
                        game_purples <= game_purples + 1;
                end
                if (dut0.checks.failed) begin
                        $display("Result: FAILED");
                        $fatal(1, "a drawing rule assertion failed");
                end
        end

        // polls once per clock and gives up after its own cycle budget
        task automatic wait_for(input int clear_goal, input int purple_goal, input string what);
                int n;
                n = 0;
                while ((clears < clear_goal || purples < purple_goal) && n < 300000) begin
                        @(posedge CLOCK_50);
                        n = n + 1;
                end
                if (clears < clear_goal || purples < purple_goal) begin
                        $display("Result: FAILED");
                        $fatal(1, "timeout while waiting for %s", what);
                end
        endtask

        initial begin
                KEY       = 1'b0;
                right_btn = 1'b0;
                left_btn  = 1'b0;
                two_pucks = 1'b0;
                repeat (8) @(posedge CLOCK_50);
                #1;
                KEY  = 1'b1;
                mode = 1;
                wait_for(2, 54, "the end of the first game with a paddle hit");
                mode = 2;
                wait_for(3, purples + 20, "the end of a game with random buttons");
                // the next restart picks up two pucks, the one after ends that game
                mode = 3;
                wait_for(5, 0, "a complete two-puck game");
                mode = 4;
                wait_for(6, 0, "a game with the left button held");
                if (dut0.checks.failed) begin
                        $display("Result: FAILED");
                        $fatal(1, "a drawing rule assertion failed");
                end else begin
                        $display("Result: PASSED");
                        $finish;
                end
        end

endmodule

// File: include/pong_params.svh
`ifndef PONG_PARAMS_SVH
`define PONG_PARAMS_SVH

// ==========================================================================
// screen geometry for the 160 by 120 frame buffer
// ==========================================================================

`define SCREEN_W 160
`define SCREEN_H 120

// border lines sit on the outermost pixels, the bottom edge stays open
`define TOP_LINE 0
`define LEFT_LINE 0
`define RIGHT_LINE 159

// ==========================================================================
// paddle and puck placement
// ==========================================================================

// the paddle covers PADDLE_W plus one columns starting at its left column
`define PADDLE_ROW 115
`define PADDLE_W 8
`define PADDLE_X_START 76
`define PADDLE_STEP 2

// faceoff points, the second column only matters in two-puck games
`define FACEOFF_X 80
`define FACEOFF_X_2 40
`define FACEOFF_Y 60

// idle cycles between frames, one eighth of a second at 50 MHz
`define FRAME_DELAY 6250000

`endif

// File: src/game_sequencer.sv
`timescale 1ns/1ps
`include "pong_params.svh"

module game_sequencer #(
        parameter int frame_delay = `FRAME_DELAY
) (
        input  logic               CLOCK_50,
        input  logic               KEY,
        input  logic               two_pucks,
        input  logic               rect_done,
        input  pong_pkg::coord_x_t paddle_x,
        input  pong_pkg::puck_t    puck0_state,
        input  pong_pkg::puck_t    puck1_state,
        input  logic               puck0_miss,
        input  logic               puck1_miss,
        output logic               rect_start,
        output pong_pkg::coord_x_t rect_x,
        output pong_pkg::coord_y_t rect_y,
        output pong_pkg::coord_x_t rect_w,
        output pong_pkg::coord_y_t rect_h,
        output pong_pkg::colour_t  rect_colour,
        output logic               paddle_restart,
        output logic               paddle_step,
        output logic               puck0_restart,
        output logic               puck0_step,
        output logic               puck1_restart,
        output logic               puck1_step
);

        // every state but init and idle owns exactly one rectangle
        typedef enum logic [3:0] {
                S_INIT, S_CLEAR, S_TOP, S_RIGHT, S_LEFT, S_IDLE,
                S_PAD_ERASE, S_PAD_DRAW, S_P0_ERASE, S_P0_DRAW,
                S_P1_ERASE, S_P1_DRAW
        } state_t;

        state_t      state;
        state_t      after_rect;
        logic        busy;
        logic        two_mode;
        logic        done_now;
        logic        miss_abort;
        logic [31:0] delay_cnt;

        // ==================================================================
        // strobes derived from the current phase
        // ==================================================================

        // busy is set while the walker owns the current rectangle
        assign done_now = busy && rect_done;

        // a puck that missed the paddle is not drawn, the game restarts
        assign miss_abort = (state == S_P0_DRAW && puck0_miss) ||
                            (state == S_P1_DRAW && puck1_miss);

        assign rect_start = (state != S_INIT) && (state != S_IDLE) && !busy && !miss_abort;

        // objects move on the last erase pixel so the draw sees the new spot
        assign paddle_step = (state == S_PAD_ERASE) && done_now;
        assign puck0_step  = (state == S_P0_ERASE) && done_now;
        assign puck1_step  = (state == S_P1_ERASE) && done_now;

        assign paddle_restart = (state == S_INIT);
        assign puck0_restart  = (state == S_INIT);
        assign puck1_restart  = (state == S_INIT);

        // phase that follows once the current rectangle is finished
        always_comb begin
                case (state)
                        S_CLEAR:     after_rect = S_TOP;
                        S_TOP:       after_rect = S_RIGHT;
                        S_RIGHT:     after_rect = S_LEFT;
                        S_PAD_ERASE: after_rect = S_PAD_DRAW;
                        S_PAD_DRAW:  after_rect = S_P0_ERASE;
                        S_P0_ERASE:  after_rect = S_P0_DRAW;
                        S_P0_DRAW:   after_rect = two_mode ? S_P1_ERASE : S_IDLE;
                        S_P1_ERASE:  after_rect = S_P1_DRAW;
                        default:     after_rect = S_IDLE;
                endcase
        end

        // ==================================================================
        // rectangle chosen for each phase
        // ==================================================================

        always_comb begin
                rect_x      = pong_pkg::coord_x_t'(`LEFT_LINE);
                rect_y      = pong_pkg::coord_y_t'(`TOP_LINE);
                rect_w      = 8'd1;
                rect_h      = 7'd1;
                rect_colour = pong_pkg::BLACK;
                case (state)
                        S_CLEAR: begin
                                rect_w = pong_pkg::coord_x_t'(`SCREEN_W);
                                rect_h = pong_pkg::coord_y_t'(`SCREEN_H);
                        end
                        S_TOP: begin
                                rect_w      = pong_pkg::coord_x_t'(`SCREEN_W);
                                rect_colour = pong_pkg::WHITE;
                        end
                        S_RIGHT, S_LEFT: begin
                                // both side columns run the full screen height
                                if (state == S_RIGHT)
                                        rect_x = pong_pkg::coord_x_t'(`RIGHT_LINE);
                                rect_h      = pong_pkg::coord_y_t'(`SCREEN_H);
                                rect_colour = pong_pkg::WHITE;
                        end
                        S_PAD_ERASE, S_PAD_DRAW: begin
                                rect_x = paddle_x;
                                rect_y = pong_pkg::coord_y_t'(`PADDLE_ROW);
                                rect_w = pong_pkg::coord_x_t'(`PADDLE_W + 1);
                                if (state == S_PAD_DRAW)
                                        rect_colour = pong_pkg::YELLOW;
                        end
                        S_P0_ERASE, S_P0_DRAW: begin
                                rect_x = puck0_state.x;
                                rect_y = puck0_state.y;
                                if (state == S_P0_DRAW)
                                        rect_colour = pong_pkg::PURPLE;
                        end
                        S_P1_ERASE, S_P1_DRAW: begin
                                rect_x = puck1_state.x;
                                rect_y = puck1_state.y;
                                if (state == S_P1_DRAW)
                                        rect_colour = pong_pkg::PURPLE;
                        end
                        default: begin
                        end
                endcase
        end

        // ==================================================================
        // phase register, frame delay and puck count
        // ==================================================================

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        state     <= S_INIT;
                        busy      <= 1'b0;
                        two_mode  <= 1'b0;
                        delay_cnt <= '0;
                end else begin
                        if (rect_start)
                                busy <= 1'b1;
                        else if (rect_done)
                                busy <= 1'b0;

                        // the counter only runs inside idle
                        if (state != S_IDLE)
                                delay_cnt <= '0;

                        case (state)
                                S_INIT: begin
                                        two_mode <= two_pucks;
                                        state    <= S_CLEAR;
                                end
                                S_IDLE: begin
                                        if (delay_cnt == 32'(frame_delay - 1)) begin
                                                delay_cnt <= '0;
                                                state     <= S_PAD_ERASE;
                                        end else begin
                                                delay_cnt <= delay_cnt + 32'd1;
                                        end
                                end
                                default: begin
                                        if (miss_abort)
                                                state <= S_INIT;
                                        else if (done_now)
                                                state <= after_rect;
                                end
                        endcase
                end
        end

endmodule

// File: src/paddle_control.sv
`timescale 1ns/1ps
`include "pong_params.svh"

module paddle_control (
        input  logic               CLOCK_50,
        input  logic               KEY,
        input  logic               paddle_restart,
        input  logic               paddle_step,
        input  logic               right_btn,
        input  logic               left_btn,
        output pong_pkg::coord_x_t paddle_x
);

        // movement stops two columns short of either limit
        localparam pong_pkg::coord_x_t right_limit =
                pong_pkg::coord_x_t'(`RIGHT_LINE - `PADDLE_W - 2);
        localparam pong_pkg::coord_x_t left_limit =
                pong_pkg::coord_x_t'(`LEFT_LINE + 2);
        localparam pong_pkg::coord_x_t step = pong_pkg::coord_x_t'(`PADDLE_STEP);

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        paddle_x <= pong_pkg::coord_x_t'(`PADDLE_X_START);
                end else if (paddle_restart) begin
                        paddle_x <= pong_pkg::coord_x_t'(`PADDLE_X_START);
                end else if (paddle_step) begin
                        // a held right button blocks the left one even at the limit
                        if (right_btn) begin
                                if (paddle_x <= right_limit)
                                        paddle_x <= paddle_x + step;
                        end else if (left_btn) begin
                                if (paddle_x >= left_limit)
                                        paddle_x <= paddle_x - step;
                        end
                end
        end

endmodule

// File: src/pong_pkg.sv
package pong_pkg;

        // column index, wide enough for 0 to 159
        typedef logic [7:0] coord_x_t;

        // row index, wide enough for 0 to 119
        typedef logic [6:0] coord_y_t;

        // 3-bit rgb as the frame-buffer adapter expects it, red in the msb
        typedef enum logic [2:0] {
                BLACK  = 3'b000,
                BLUE   = 3'b001,
                GREEN  = 3'b010,
                CYAN   = 3'b011,
                RED    = 3'b100,
                PURPLE = 3'b101,
                YELLOW = 3'b110,
                WHITE  = 3'b111
        } colour_t;

        // position and heading of one puck
        // a set direction bit means the puck moves toward smaller values
        typedef struct packed {
                coord_x_t x;
                coord_y_t y;
                logic     left;
                logic     up;
        } puck_t;

endpackage

// File: src/pong_top.sv
`timescale 1ns/1ps
`include "pong_params.svh"

module pong_top #(
        parameter int frame_delay = `FRAME_DELAY
) (
        input  logic               CLOCK_50,
        input  logic               KEY,
        input  logic               right_btn,
        input  logic               left_btn,
        input  logic               two_pucks,
        output logic               plot,
        output pong_pkg::coord_x_t draw_x,
        output pong_pkg::coord_y_t draw_y,
        output pong_pkg::colour_t  colour
);

        // rectangle command from the sequencer to the pixel walker
        logic               rect_start;
        logic               rect_done;
        pong_pkg::coord_x_t rect_x;
        pong_pkg::coord_y_t rect_y;
        pong_pkg::coord_x_t rect_w;
        pong_pkg::coord_y_t rect_h;
        pong_pkg::colour_t  rect_colour;

        // game objects and their update strobes
        logic               paddle_restart;
        logic               paddle_step;
        pong_pkg::coord_x_t paddle_x;
        logic               puck0_restart;
        logic               puck0_step;
        logic               puck0_miss;
        pong_pkg::puck_t    puck0_state;
        logic               puck1_restart;
        logic               puck1_step;
        logic               puck1_miss;
        pong_pkg::puck_t    puck1_state;

        game_sequencer #(.frame_delay(frame_delay)) sequencer (.*);

        rect_walker walker (.*);

        paddle_control paddle (.*);

        // the two pucks leave their faceoff points heading apart
        puck_motion #(.start_x(`FACEOFF_X), .start_left(1'b0)) puck0 (
                .CLOCK_50    (CLOCK_50),
                .KEY         (KEY),
                .puck_restart(puck0_restart),
                .puck_step   (puck0_step),
                .paddle_x    (paddle_x),
                .puck_state  (puck0_state),
                .miss        (puck0_miss)
        );

        puck_motion #(.start_x(`FACEOFF_X_2), .start_left(1'b1)) puck1 (
                .CLOCK_50    (CLOCK_50),
                .KEY         (KEY),
                .puck_restart(puck1_restart),
                .puck_step   (puck1_step),
                .paddle_x    (paddle_x),
                .puck_state  (puck1_state),
                .miss        (puck1_miss)
        );

endmodule

// File: src/puck_motion.sv
`timescale 1ns/1ps
`include "pong_params.svh"

module puck_motion #(
        parameter int   start_x    = `FACEOFF_X,
        parameter logic start_left = 1'b0
) (
        input  logic               CLOCK_50,
        input  logic               KEY,
        input  logic               puck_restart,
        input  logic               puck_step,
        input  pong_pkg::coord_x_t paddle_x,
        output pong_pkg::puck_t    puck_state,
        output logic               miss
);

        // faceoff point and heading, every puck starts toward the paddle
        localparam pong_pkg::puck_t faceoff = '{
                x:    pong_pkg::coord_x_t'(start_x),
                y:    pong_pkg::coord_y_t'(`FACEOFF_Y),
                left: start_left,
                up:   1'b0
        };

        pong_pkg::coord_x_t next_x;
        pong_pkg::coord_y_t next_y;
        logic               on_paddle_row;
        logic               over_paddle;

        // one pixel diagonally along the current heading
        assign next_x = puck_state.left ? puck_state.x - 8'd1 : puck_state.x + 8'd1;
        assign next_y = puck_state.up ? puck_state.y - 7'd1 : puck_state.y + 7'd1;

        assign on_paddle_row = (next_y == pong_pkg::coord_y_t'(`PADDLE_ROW - 1));
        assign over_paddle   = (next_x >= paddle_x) &&
                               (next_x <= paddle_x + pong_pkg::coord_x_t'(`PADDLE_W));

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        puck_state <= faceoff;
                        miss       <= 1'b0;
                end else if (puck_restart) begin
                        puck_state <= faceoff;
                        miss       <= 1'b0;
                end else if (puck_step) begin
                        puck_state.x <= next_x;
                        puck_state.y <= next_y;
                        miss         <= on_paddle_row && !over_paddle;

                        // bounces are judged at the position just reached
                        if (next_y == pong_pkg::coord_y_t'(`TOP_LINE + 1))
                                puck_state.up <= ~puck_state.up;
                        else if (on_paddle_row && over_paddle)
                                puck_state.up <= ~puck_state.up;

                        if (next_x == pong_pkg::coord_x_t'(`LEFT_LINE + 1) ||
                            next_x == pong_pkg::coord_x_t'(`RIGHT_LINE - 1))
                                puck_state.left <= ~puck_state.left;
                end
        end

endmodule

// File: src/rect_walker.sv
`timescale 1ns/1ps

module rect_walker (
        input  logic               CLOCK_50,
        input  logic               KEY,
        input  logic               rect_start,
        input  pong_pkg::coord_x_t rect_x,
        input  pong_pkg::coord_y_t rect_y,
        input  pong_pkg::coord_x_t rect_w,
        input  pong_pkg::coord_y_t rect_h,
        input  pong_pkg::colour_t  rect_colour,
        output logic               plot,
        output pong_pkg::coord_x_t draw_x,
        output pong_pkg::coord_y_t draw_y,
        output pong_pkg::colour_t  colour,
        output logic               rect_done
);

        // latched rectangle, kept as first column and last column and row
        pong_pkg::coord_x_t x_first;
        pong_pkg::coord_x_t x_last;
        pong_pkg::coord_y_t y_last;
        pong_pkg::coord_x_t cur_x;
        pong_pkg::coord_y_t cur_y;
        pong_pkg::colour_t  colour_q;
        logic               active;

        assign plot      = active;
        assign draw_x    = cur_x;
        assign draw_y    = cur_y;
        assign colour    = colour_q;
        assign rect_done = active && (cur_x == x_last) && (cur_y == y_last);

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY)
                        active <= 1'b0;
                else if (rect_start)
                        active <= 1'b1;
                else if (rect_done)
                        active <= 1'b0;
        end

        // row-major sweep, the column wraps to the latched left edge
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        x_first  <= '0;
                        x_last   <= '0;
                        y_last   <= '0;
                        cur_x    <= '0;
                        cur_y    <= '0;
                        colour_q <= pong_pkg::BLACK;
                end else if (rect_start) begin
                        x_first  <= rect_x;
                        x_last   <= rect_x + rect_w - 8'd1;
                        y_last   <= rect_y + rect_h - 7'd1;
                        cur_x    <= rect_x;
                        cur_y    <= rect_y;
                        colour_q <= rect_colour;
                end else if (active && !rect_done) begin
                        if (cur_x == x_last) begin
                                cur_x <= x_first;
                                cur_y <= cur_y + 7'd1;
                        end else begin
                                cur_x <= cur_x + 8'd1;
                        end
                end
        end

endmodule

// File: verilog.f
+incdir+include
src/pong_pkg.sv
src/rect_walker.sv
src/paddle_control.sv
src/puck_motion.sv
src/game_sequencer.sv
src/pong_top.sv
dv/pong_sva.sv
dv/pong_tb.sv
